// ==== coproc.f ====
+incdir+.
coproc_pkg.sv
cp_dispatch.sv
csr_file.sv
muldiv_unit.sv
bitops_unit.sv
coproc_top.sv
tb_clock_gen.sv
tb_coproc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_coproc -f coproc.f -o sim_coproc &&
./obj_dir/sim_coproc | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "Simulation passed" ||
{ echo "Simulation failed" >&2; exit 1; }

// ==== tb_coproc.sv ====
// ====================
// Table-driven testbench for the coprocessor top level
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module tb_coproc;

    typedef struct packed {
        coproc_pkg::cp_word_t instr;
        coproc_pkg::cp_word_t rs1_data;
        coproc_pkg::cp_word_t rs2_data;
        logic                 det;
        coproc_pkg::cp_word_t expected;
        logic [1:0]           cyc;      // 0 plain, 1 counter base, 2 counter delta
    } row_t;

    logic                 clk;
    logic                 rst_n;
    coproc_pkg::cp_req_t  req;
    coproc_pkg::cp_resp_t resp;
    logic                 busy;
    logic                 detected;

    row_t                 rows[$];
    string                names[$];
    coproc_pkg::cp_word_t rng_state;
    int                   edge_cnt;
    int                   cycle_limit;
    coproc_pkg::cp_word_t cyc_base_val;
    int                   cyc_base_edge;

    tb_clock_gen tb_clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    coproc_top coproc_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .resp     (resp),
        .busy     (busy),
        .detected (detected)
    );

    // ====================
    // Reporting and compare tasks
    task automatic fail_run(input string why);
        $display("ERROR: %s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string nm, input coproc_pkg::cp_word_t exp,
                              input coproc_pkg::cp_word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", nm, exp, act);
            fail_run("result word differs from the expected value");
        end
    endtask

    task automatic check_detect(input string nm, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected detected %b, actual %b", nm, exp, act);
            fail_run("detected flag differs from the expected value");
        end
    endtask

    // ====================
    // Stimulus helpers and reference model
    function automatic coproc_pkg::cp_word_t xorshift_next();
        coproc_pkg::cp_word_t s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic coproc_pkg::cp_word_t enc_rtype(input logic [6:0] f7,
                                                       input logic [2:0] f3,
                                                       input logic [6:0] opc);
        return {f7, 5'd3, 5'd2, f3, 5'd1, opc};  // rs2=x3, rs1=x2, rd=x1
    endfunction

    function automatic coproc_pkg::cp_word_t enc_csr(input logic [11:0] addr,
                                                     input logic [4:0] rs1f,
                                                     input logic [2:0] f3);
        return {addr, rs1f, f3, 5'd1, `CP_OP_SYSTEM};
    endfunction

    // Edges from accept to result
    function automatic int latency_of(input coproc_pkg::cp_word_t instr);
        if (instr[6:0] != `CP_OP_OP)
            return 1;
        else if (instr[14])
            return `DIV_LATENCY;
        else
            return `MUL_LATENCY;
    endfunction

    function automatic coproc_pkg::cp_word_t ref_muldiv(input logic [2:0] fn,
                                                        input coproc_pkg::cp_word_t a,
                                                        input coproc_pkg::cp_word_t b);
        logic signed [63:0]   sa;
        logic signed [63:0]   sb;
        logic signed [63:0]   ub;
        logic signed [63:0]   p;
        logic [63:0]          pu;
        int                   ia;
        int                   ib;
        coproc_pkg::cp_word_t r;
        sa = 64'($signed(a));
        sb = 64'($signed(b));
        ub = 64'(b);
        pu = 64'(a) * 64'(b);
        ia = a;
        ib = b;
        p  = '0;
        case (fn)
            3'd0: r = a * b;
            3'd1: begin
                p = sa * sb;
                r = p[63:32];
            end
            3'd2: begin
                p = sa * ub;  // Signed times unsigned
                r = p[63:32];
            end
            3'd3: r = pu[63:32];
            3'd4: begin
                if (b == 32'd0)
                    r = 32'hFFFF_FFFF;
                else if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF)
                    r = a;
                else
                    r = ia / ib;
            end
            3'd5: begin
                if (b == 32'd0)
                    r = 32'hFFFF_FFFF;
                else
                    r = a / b;
            end
            3'd6: begin
                if (b == 32'd0)
                    r = a;
                else if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF)
                    r = 32'd0;
                else
                    r = ia % ib;
            end
            default: begin
                if (b == 32'd0)
                    r = a;
                else
                    r = a % b;
            end
        endcase
        return r;
    endfunction

    function automatic coproc_pkg::cp_word_t ref_bitop(input logic [2:0] fn,
                                                       input coproc_pkg::cp_word_t a,
                                                       input coproc_pkg::cp_word_t b);
        int                   n;
        coproc_pkg::cp_word_t r;
        n = 0;
        case (fn)
            3'd0: r = a & b;
            3'd1: r = a | b;
            3'd2: r = a ^ b;
            3'd3: r = ~a;
            3'd4: begin
                while (n < 32 && a[31 - n] == 1'b0)
                    n++;
                r = n;
            end
            3'd5: begin
                while (n < 32 && a[n] == 1'b0)
                    n++;
                r = n;
            end
            3'd6: r = $countones(a);
            default: r = {a[15:0], b[15:0]};
        endcase
        return r;
    endfunction

    task automatic add_row(input string nm, input coproc_pkg::cp_word_t instr,
                           input coproc_pkg::cp_word_t a, input coproc_pkg::cp_word_t b,
                           input logic det, input coproc_pkg::cp_word_t expv,
                           input logic [1:0] cyc);
        row_t r;
        r.instr    = instr;
        r.rs1_data = a;
        r.rs2_data = b;
        r.det      = det;
        r.expected = expv;
        r.cyc      = cyc;
        rows.push_back(r);
        names.push_back(nm);
    endtask

    // ====================
    // Stimulus table
    task automatic build_table();
        coproc_pkg::cp_word_t ra;
        coproc_pkg::cp_word_t rb;
        coproc_pkg::cp_word_t ea[4];
        coproc_pkg::cp_word_t eb[4];
        // Not for the coprocessor
        add_row("add_plain", enc_rtype(7'd0, 3'b000, `CP_OP_OP), 32'd5, 32'd7,
                1'b0, 32'd0, 2'd0);
        add_row("ecall", 32'h0000_0073, 32'd0, 32'd0, 1'b0, 32'd0, 2'd0);
        add_row("load_word", 32'h0000_2083, 32'd0, 32'd0, 1'b0, 32'd0, 2'd0);
        add_row("system_f3_100", enc_csr(`CSR_MSTATUS, 5'd0, 3'b100), 32'd0, 32'd0,
                1'b0, 32'd0, 2'd0);

        ra = xorshift_next();
        rb = xorshift_next();   // Ignored by the immediate forms
        add_row("mstatus_reset", enc_csr(`CSR_MSTATUS, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, `MSTATUS_RESET, 2'd0);
        add_row("mscratch_swap", enc_csr(`CSR_MSCRATCH, 5'd2, 3'b001), ra, 32'd0,
                1'b1, 32'd0, 2'd0);
        add_row("mscratch_read", enc_csr(`CSR_MSCRATCH, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, ra, 2'd0);
        add_row("mie_set", enc_csr(`CSR_MIE, 5'd2, 3'b010), 32'h0000_0888, 32'd0,
                1'b1, 32'd0, 2'd0);
        add_row("mie_clear", enc_csr(`CSR_MIE, 5'd2, 3'b011), 32'h0000_0008, 32'd0,
                1'b1, 32'h0000_0888, 2'd0);
        add_row("mie_read", enc_csr(`CSR_MIE, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, 32'h0000_0880, 2'd0);
        add_row("mtvec_write_imm", enc_csr(`CSR_MTVEC, 5'h1F, 3'b101), rb, 32'd0,
                1'b1, 32'd0, 2'd0);
        add_row("mtvec_clear_imm", enc_csr(`CSR_MTVEC, 5'h05, 3'b111), rb, 32'd0,
                1'b1, 32'h0000_001F, 2'd0);
        add_row("mtvec_set_imm", enc_csr(`CSR_MTVEC, 5'h04, 3'b110), rb, 32'd0,
                1'b1, 32'h0000_001A, 2'd0);
        add_row("mtvec_read", enc_csr(`CSR_MTVEC, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, 32'h0000_001E, 2'd0);
        add_row("misa_read", enc_csr(`CSR_MISA, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, `MISA_VALUE, 2'd0);
        add_row("misa_write", enc_csr(`CSR_MISA, 5'd2, 3'b001), rb, 32'd0,
                1'b1, `MISA_VALUE, 2'd0);
        add_row("misa_after", enc_csr(`CSR_MISA, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, `MISA_VALUE, 2'd0);
        add_row("unknown_write", enc_csr(12'h7C0, 5'd2, 3'b001), ra, 32'd0,
                1'b1, 32'd0, 2'd0);
        add_row("unknown_read", enc_csr(12'h7C0, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, 32'd0, 2'd0);

        // Counter reads with a divide in between
        add_row("cycle_base", enc_csr(`CSR_CYCLE, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, 32'd0, 2'd1);
        add_row("cycle_gap_div", enc_rtype(`CP_FUNCT7_MULDIV, 3'b100, `CP_OP_OP), ra, rb,
                1'b1, ref_muldiv(3'b100, ra, rb), 2'd0);
        add_row("cycle_delta", enc_csr(`CSR_CYCLE, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, 32'd0, 2'd2);
        add_row("cycleh_zero", enc_csr(`CSR_CYCLEH, 5'd0, 3'b010), 32'd0, 32'd0,
                1'b1, 32'd0, 2'd0);

        // RV32M, random, overflow, divide by zero, negative dividend
        for (int fn = 0; fn < 8; fn++) begin
            ea[0] = xorshift_next();
            eb[0] = xorshift_next();
            ea[1] = 32'h8000_0000;
            eb[1] = 32'hFFFF_FFFF;
            ea[2] = xorshift_next();
            eb[2] = 32'd0;
            ea[3] = 32'hFFFF_FFF9;
            eb[3] = 32'd2;
            for (int j = 0; j < 4; j++)
                add_row($sformatf("mdu_f%0d_%0d", fn, j),
                        enc_rtype(`CP_FUNCT7_MULDIV, 3'(fn), `CP_OP_OP), ea[j], eb[j],
                        1'b1, ref_muldiv(3'(fn), ea[j], eb[j]), 2'd0);
        end

        for (int fn = 0; fn < 8; fn++) begin
            ra = xorshift_next();
            rb = xorshift_next();
            add_row($sformatf("bit_f%0d_rand", fn), enc_rtype(7'd0, 3'(fn), `CP_OP_CUSTOM0),
                    ra, rb, 1'b1, ref_bitop(3'(fn), ra, rb), 2'd0);
        end
        for (int fn = 4; fn < 7; fn++) begin   // Counting ops on the extremes
            add_row($sformatf("bit_f%0d_zero", fn), enc_rtype(7'h15, 3'(fn), `CP_OP_CUSTOM1),
                    32'd0, 32'hFFFF_FFFF, 1'b1, ref_bitop(3'(fn), 32'd0, 32'hFFFF_FFFF), 2'd0);
            add_row($sformatf("bit_f%0d_ones", fn), enc_rtype(7'h15, 3'(fn), `CP_OP_CUSTOM1),
                    32'hFFFF_FFFF, 32'd0, 1'b1, ref_bitop(3'(fn), 32'hFFFF_FFFF, 32'd0), 2'd0);
        end
    endtask

    // ====================
    // Row execution
    // Starts at the negedge after the accept edge, ends at the result negedge
    task automatic await_result(input string nm, input int lat, input logic is_mdu);
        for (int k = 0; k <= lat; k++) begin
            @(negedge clk);
            if (busy !== (is_mdu && k < lat))
                fail_run($sformatf("%s: busy is %b %0d edges after accept", nm, busy, k));
            if (k < lat && resp.valid)
                fail_run($sformatf("%s: response came early, %0d edges after accept", nm, k));
            if (k == lat && resp.valid !== 1'b1)
                fail_run($sformatf("%s: response is missing %0d edges after accept", nm, lat));
        end
    endtask

    task automatic run_row(input int idx);
        row_t  r;
        string nm;
        int    acc_edge;
        r  = rows[idx];
        nm = names[idx];
        req.valid    = 1'b1;
        req.instr    = coproc_pkg::cp_instr_u'(r.instr);
        req.rs1_data = r.rs1_data;
        req.rs2_data = r.rs2_data;
        @(negedge clk);
        check_detect(nm, r.det, detected);
        if (resp.valid)
            fail_run($sformatf("%s: response present before the request", nm));
        if (!r.det) begin
            @(posedge clk);
            #1;
            req.valid = 1'b0;
            repeat (6) begin
                @(negedge clk);
                if (resp.valid || busy)
                    fail_run($sformatf("%s: ignored instruction produced activity", nm));
            end
        end else begin
            while (busy)
                @(negedge clk);
            @(posedge clk);         // Accept edge
            #1;
            acc_edge  = edge_cnt;
            req.valid = 1'b0;
            await_result(nm, latency_of(r.instr), r.instr[6:0] == `CP_OP_OP);
            case (r.cyc)
                2'd1: begin
                    cyc_base_val  = resp.data;
                    cyc_base_edge = acc_edge;
                end
                2'd2: check_word(nm, cyc_base_val + (acc_edge - cyc_base_edge), resp.data);
                default: check_word(nm, r.expected, resp.data);
            endcase
        end
        @(posedge clk);
        #1;
    endtask

    // Second request held on the bus while a divide is in flight
    task automatic issue_during_busy();
        coproc_pkg::cp_word_t a0;
        coproc_pkg::cp_word_t b0;
        coproc_pkg::cp_word_t a1;
        coproc_pkg::cp_word_t b1;
        a0 = xorshift_next();
        b0 = xorshift_next();
        a1 = xorshift_next();
        b1 = xorshift_next();
        req.valid    = 1'b1;
        req.instr    = coproc_pkg::cp_instr_u'(enc_rtype(`CP_FUNCT7_MULDIV, 3'b100, `CP_OP_OP));
        req.rs1_data = a0;
        req.rs2_data = b0;
        @(negedge clk);
        check_detect("held_div", 1'b1, detected);
        @(posedge clk);
        #1;
        req.instr    = coproc_pkg::cp_instr_u'(enc_rtype(`CP_FUNCT7_MULDIV, 3'b000, `CP_OP_OP));
        req.rs1_data = a1;
        req.rs2_data = b1;
        await_result("held_div", `DIV_LATENCY, 1'b1);
        check_word("held_div", ref_muldiv(3'b100, a0, b0), resp.data);
        check_detect("held_mul", 1'b1, detected);
        @(posedge clk);             // First edge with busy low
        #1;
        req.valid = 1'b0;
        await_result("held_mul", `MUL_LATENCY, 1'b1);
        check_word("held_mul", ref_muldiv(3'b000, a1, b1), resp.data);
        @(posedge clk);
        #1;
    endtask

    // ====================
    // Run control
    always @(posedge clk) begin
        edge_cnt = edge_cnt + 1;
        if (edge_cnt > cycle_limit)
            fail_run("simulation ran past its cycle limit without finishing");
    end

    initial begin
        req           = '0;
        rng_state     = 32'd22;
        edge_cnt      = 0;
        cyc_base_val  = '0;
        cyc_base_edge = 0;
        build_table();
        // Held pair counts as two more rows
        cycle_limit = (rows.size() + 2) * (`DIV_LATENCY + 4) + 20;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        for (int i = 0; i < rows.size(); i++)
            run_row(i);
        issue_during_busy();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// ====================
// Testbench clock and reset source
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // Reset low for the first 3 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== coproc_top.sv ====
// ====================
// Coprocessor top: dispatcher and three units
// ====================
`timescale 1ns/1ps
`default_nettype none

module coproc_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire coproc_pkg::cp_req_t  req,
    output coproc_pkg::cp_resp_t      resp,
    output logic                      busy,
    output logic                      detected
);

    coproc_pkg::cp_op_t   op;
    coproc_pkg::cp_resp_t csr_resp;
    coproc_pkg::cp_resp_t mdu_resp;
    coproc_pkg::cp_resp_t bit_resp;
    logic                 csr_start;
    logic                 mdu_start;
    logic                 bit_start;
    logic                 mdu_busy;

    cp_dispatch cp_dispatch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .unit_busy (mdu_busy),
        .csr_resp  (csr_resp),
        .mdu_resp  (mdu_resp),
        .bit_resp  (bit_resp),
        .csr_start (csr_start),
        .mdu_start (mdu_start),
        .bit_start (bit_start),
        .op        (op),
        .resp      (resp),
        .busy      (busy),
        .detected  (detected)
    );

    csr_file csr_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (csr_start),
        .op    (op),
        .resp  (csr_resp)
    );

    muldiv_unit muldiv_unit_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mdu_start),
        .op    (op),
        .resp  (mdu_resp),
        .busy  (mdu_busy)
    );

    bitops_unit bitops_unit_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (bit_start),
        .op    (op),
        .resp  (bit_resp)
    );

endmodule

`default_nettype wire

// ==== bitops_unit.sv ====
// ====================
// Custom-0/1 bit operations
// ====================
`timescale 1ns/1ps
`default_nettype none

module bitops_unit (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire coproc_pkg::cp_op_t  op,
    output coproc_pkg::cp_resp_t     resp
);

    logic               pend_q;
    coproc_pkg::cp_op_t op_q;
    logic               valid_q;
    logic [31:0]        result_q;
    logic [31:0]        result_c;

    function automatic logic [5:0] lead_zeros(input logic [31:0] v);
        logic [5:0] n;
        logic       hit;
        n   = 6'd0;
        hit = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (v[i])
                hit = 1'b1;
            else if (!hit)
                n = n + 6'd1;
        end
        return n;
    endfunction

    function automatic logic [5:0] trail_zeros(input logic [31:0] v);
        logic [5:0] n;
        logic       hit;
        n   = 6'd0;
        hit = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (v[i])
                hit = 1'b1;
            else if (!hit)
                n = n + 6'd1;
        end
        return n;
    endfunction

    function automatic logic [5:0] pop_count(input logic [31:0] v);
        logic [5:0] n;
        n = 6'd0;
        for (int i = 0; i < 32; i++)
            n = n + {5'd0, v[i]};
        return n;
    endfunction

    always_comb begin
        case (op_q.funct3)
            3'b000:  result_c = op_q.rs1_data & op_q.rs2_data;
            3'b001:  result_c = op_q.rs1_data | op_q.rs2_data;
            3'b010:  result_c = op_q.rs1_data ^ op_q.rs2_data;
            3'b011:  result_c = ~op_q.rs1_data;
            3'b100:  result_c = {26'd0, lead_zeros(op_q.rs1_data)};
            3'b101:  result_c = {26'd0, trail_zeros(op_q.rs1_data)};
            3'b110:  result_c = {26'd0, pop_count(op_q.rs1_data)};
            default: result_c = {op_q.rs1_data[15:0], op_q.rs2_data[15:0]}; // Pack halves
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            pend_q  <= start;
            valid_q <= pend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            op_q <= op;
        if (pend_q)
            result_q <= result_c;
    end

    assign resp.valid = valid_q;
    assign resp.data  = result_q;

endmodule

`default_nettype wire

// ==== muldiv_unit.sv ====
// ====================
// RV32M multiply/divide, fixed latency countdown
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module muldiv_unit (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire coproc_pkg::cp_op_t  op,
    output coproc_pkg::cp_resp_t     resp,
    output logic                     busy
);

    // Operands latched at accept
    coproc_pkg::cp_mdu_fn_e fn_q;
    logic [31:0]            a_q;
    logic [31:0]            b_q;

    logic [2:0] cnt_q;
    logic       busy_q;
    logic       done;

    logic        valid_q;
    logic [31:0] result_q;

    logic [63:0] prod_ss;
    logic [63:0] prod_su;
    logic [63:0] prod_uu;
    logic [31:0] quot_s;
    logic [31:0] rem_s;
    logic        div_zero;
    logic        div_ovf;
    logic [31:0] result_c;

    // ====================
    // Countdown control
    assign done = busy_q && (cnt_q == 3'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= done;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= op.funct3[2] ? 3'(`DIV_LATENCY - 1) : 3'(`MUL_LATENCY - 1);
            end else if (done) begin
                busy_q <= 1'b0;   // Drops on the result edge
            end else if (busy_q) begin
                cnt_q <= cnt_q - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            fn_q <= coproc_pkg::cp_mdu_fn_e'(op.funct3);
            a_q  <= op.rs1_data;
            b_q  <= op.rs2_data;
        end
        if (done)
            result_q <= result_c;
    end

    // ====================
    // Datapath
    // Low 64 bits of the extended products are exact
    assign prod_ss = {{32{a_q[31]}}, a_q} * {{32{b_q[31]}}, b_q};
    assign prod_su = {{32{a_q[31]}}, a_q} * {32'd0, b_q};
    assign prod_uu = {32'd0, a_q} * {32'd0, b_q};

    assign div_zero = (b_q == 32'd0);
    assign div_ovf  = (a_q == 32'h8000_0000) && (b_q == 32'hFFFF_FFFF);
    assign quot_s   = $signed(a_q) / $signed(b_q);
    assign rem_s    = $signed(a_q) % $signed(b_q);

    always_comb begin
        case (fn_q)
            coproc_pkg::MDU_MUL:    result_c = prod_uu[31:0];
            coproc_pkg::MDU_MULH:   result_c = prod_ss[63:32];
            coproc_pkg::MDU_MULHSU: result_c = prod_su[63:32];
            coproc_pkg::MDU_MULHU:  result_c = prod_uu[63:32];
            coproc_pkg::MDU_DIV: begin
                if (div_zero)
                    result_c = 32'hFFFF_FFFF;
                else if (div_ovf)
                    result_c = 32'h8000_0000;   // Most negative / -1
                else
                    result_c = quot_s;
            end
            coproc_pkg::MDU_DIVU: result_c = div_zero ? 32'hFFFF_FFFF : a_q / b_q;
            coproc_pkg::MDU_REM: begin
                if (div_zero)
                    result_c = a_q;
                else if (div_ovf)
                    result_c = 32'd0;
                else
                    result_c = rem_s;
            end
            coproc_pkg::MDU_REMU: result_c = div_zero ? a_q : a_q % b_q;
            default:              result_c = '0;
        endcase
    end

    assign resp.valid = valid_q;
    assign resp.data  = result_q;
    assign busy       = busy_q;

    // Dispatcher must hold issue while an operation is in flight
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !busy_q
    );

endmodule

`default_nettype wire

// ==== csr_file.sv ====
// ====================
// Machine CSRs, cycle counter, CSRRW/CSRRS/CSRRC
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module csr_file (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire coproc_pkg::cp_op_t  op,
    output coproc_pkg::cp_resp_t     resp
);

    logic               pend_q;
    coproc_pkg::cp_op_t op_q;

    logic [31:0] mstatus_q;
    logic [31:0] mie_q;
    logic [31:0] mtvec_q;
    logic [31:0] mscratch_q;
    logic [63:0] cycle_q;

    coproc_pkg::cp_word_t old_val;
    coproc_pkg::cp_word_t src_val;
    coproc_pkg::cp_word_t new_val;

    logic                 valid_q;
    coproc_pkg::cp_word_t data_q;

    // ====================
    // Issue stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            op_q <= op;
    end

    // ====================
    // Read and modify
    always_comb begin
        case (op_q.csr_addr)
            `CSR_MSTATUS:  old_val = mstatus_q;
            `CSR_MISA:     old_val = `MISA_VALUE;
            `CSR_MIE:      old_val = mie_q;
            `CSR_MTVEC:    old_val = mtvec_q;
            `CSR_MSCRATCH: old_val = mscratch_q;
            `CSR_CYCLE:    old_val = cycle_q[31:0];
            `CSR_CYCLEH:   old_val = cycle_q[63:32];
            default:       old_val = '0;         // Unmapped reads as zero
        endcase
    end

    assign src_val = op_q.funct3[2] ? {27'd0, op_q.rs1} : op_q.rs1_data;

    always_comb begin
        case (op_q.funct3[1:0])
            2'b01:   new_val = src_val;             // Swap
            2'b10:   new_val = old_val | src_val;   // Set bits
            2'b11:   new_val = old_val & ~src_val;  // Clear bits
            default: new_val = old_val;
        endcase
    end

    // ====================
    // Write back and counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q  <= `MSTATUS_RESET;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            cycle_q    <= '0;
            valid_q    <= 1'b0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
            valid_q <= pend_q;
            if (pend_q) begin
                // misa, cycle, cycleh and unmapped addresses drop the write
                case (op_q.csr_addr)
                    `CSR_MSTATUS:  mstatus_q  <= new_val;
                    `CSR_MIE:      mie_q      <= new_val;
                    `CSR_MTVEC:    mtvec_q    <= new_val;
                    `CSR_MSCRATCH: mscratch_q <= new_val;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pend_q)
            data_q <= old_val;  // Value before the write
    end

    assign resp.valid = valid_q;
    assign resp.data  = data_q;

endmodule

`default_nettype wire

// ==== cp_dispatch.sv ====
// ====================
// Decode, unit select, issue gating and response merge
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "coproc_defines.svh"

module cp_dispatch (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire coproc_pkg::cp_req_t  req,
    input  wire logic                 unit_busy,
    input  wire coproc_pkg::cp_resp_t csr_resp,
    input  wire coproc_pkg::cp_resp_t mdu_resp,
    input  wire coproc_pkg::cp_resp_t bit_resp,
    output logic                      csr_start,
    output logic                      mdu_start,
    output logic                      bit_start,
    output coproc_pkg::cp_op_t        op,
    output coproc_pkg::cp_resp_t      resp,
    output logic                      busy,
    output logic                      detected
);

    coproc_pkg::cp_instr_u instr;
    coproc_pkg::cp_unit_e  unit;
    logic                  accept;

    assign instr = req.instr;

    // ====================
    // Classification
    always_comb begin
        unit = coproc_pkg::CP_UNIT_NONE;
        case (instr.r_view.opcode)
            `CP_OP_SYSTEM: begin
                // funct3 000 and 100 belong to the core
                if (instr.csr_view.funct3[1:0] != 2'b00)
                    unit = coproc_pkg::CP_UNIT_CSR;
            end
            `CP_OP_OP: begin
                if (instr.r_view.funct7 == `CP_FUNCT7_MULDIV)
                    unit = coproc_pkg::CP_UNIT_MULDIV;
            end
            `CP_OP_CUSTOM0, `CP_OP_CUSTOM1: unit = coproc_pkg::CP_UNIT_BITOP;
            default: unit = coproc_pkg::CP_UNIT_NONE;
        endcase
    end

    assign detected = req.valid && (unit != coproc_pkg::CP_UNIT_NONE);
    assign busy     = unit_busy;                // Only the MDU holds off issue
    assign accept   = detected && !unit_busy;

    assign csr_start = accept && (unit == coproc_pkg::CP_UNIT_CSR);
    assign mdu_start = accept && (unit == coproc_pkg::CP_UNIT_MULDIV);
    assign bit_start = accept && (unit == coproc_pkg::CP_UNIT_BITOP);

    // Shared operand bundle, only the strobed unit picks it up
    assign op = '{
        funct3:   instr.csr_view.funct3,
        rs1:      instr.csr_view.rs1,
        csr_addr: instr.csr_view.csr,
        rs1_data: req.rs1_data,
        rs2_data: req.rs2_data
    };

    // ====================
    // Response merge
    assign resp.valid = csr_resp.valid | mdu_resp.valid | bit_resp.valid;
    assign resp.data  = ({32{csr_resp.valid}} & csr_resp.data)
                      | ({32{mdu_resp.valid}} & mdu_resp.data)
                      | ({32{bit_resp.valid}} & bit_resp.data);

    // Latencies and busy gating keep unit results apart
    a_resp_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({csr_resp.valid, mdu_resp.valid, bit_resp.valid})
    );

endmodule

`default_nettype wire

// ==== coproc_pkg.sv ====
// ====================
// Coprocessor types: instruction union, request/response structs, enums
// ====================
`default_nettype none

package coproc_pkg;

    typedef logic [31:0] cp_word_t;

    // ====================
    // Instruction views
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } cp_rtype_t;

    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;     // Also zimm for the immediate forms
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } cp_csrtype_t;

    typedef union packed {
        cp_rtype_t   r_view;
        cp_csrtype_t csr_view;
    } cp_instr_u;

    // ====================
    // Unit select and RV32M function codes
    typedef enum logic [1:0] {
        CP_UNIT_NONE   = 2'b00,
        CP_UNIT_CSR    = 2'b01,
        CP_UNIT_MULDIV = 2'b10,
        CP_UNIT_BITOP  = 2'b11
    } cp_unit_e;

    typedef enum logic [2:0] {
        MDU_MUL    = 3'b000,
        MDU_MULH   = 3'b001,
        MDU_MULHSU = 3'b010,
        MDU_MULHU  = 3'b011,
        MDU_DIV    = 3'b100,
        MDU_DIVU   = 3'b101,
        MDU_REM    = 3'b110,
        MDU_REMU   = 3'b111
    } cp_mdu_fn_e;

    // ====================
    // Transfers
    typedef struct packed {
        logic      valid;
        cp_instr_u instr;
        cp_word_t  rs1_data;
        cp_word_t  rs2_data;
    } cp_req_t;

    typedef struct packed {
        logic [2:0]  funct3;
        logic [4:0]  rs1;
        logic [11:0] csr_addr;
        cp_word_t    rs1_data;
        cp_word_t    rs2_data;
    } cp_op_t;

    typedef struct packed {
        logic     valid;
        cp_word_t data;
    } cp_resp_t;

endpackage

`default_nettype wire

// ==== coproc_defines.svh ====
// ====================
// Opcodes, CSR addresses, CSR reset values
// and multiply/divide latencies
// ====================
`ifndef COPROC_DEFINES_SVH
`define COPROC_DEFINES_SVH

// ====================
// Major opcodes
`define CP_OP_SYSTEM      7'b1110011
`define CP_OP_OP          7'b0110011
`define CP_OP_CUSTOM0     7'b0001011
`define CP_OP_CUSTOM1     7'b0101011

`define CP_FUNCT7_MULDIV  7'b0000001  // RV32M marker in funct7

// ====================
// CSR addresses
`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MSCRATCH      12'h340
`define CSR_CYCLE         12'hC00
`define CSR_CYCLEH        12'hC80

// MPP = 11, machine mode
`define MSTATUS_RESET     32'h0000_1800

// MXL = 1 (RV32), I and M bits
`define MISA_VALUE        32'h4000_1100

// Edges from accept to result
`define MUL_LATENCY       3
`define DIV_LATENCY       5

`endif
